// ==== posit_mult.f ====
+incdir+include
rtl/posit_cfg_pkg.sv
rtl/posit_types_pkg.sv
rtl/posit_decode.sv
rtl/posit_execute.sv
rtl/posit_result.sv
rtl/posit_mult.sv
testbench/posit_mult_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the posit multiplier testbench with Verilator, run it, grep the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module posit_mult_tb -f posit_mult.f -o posit_mult_sim \
	&& ./obj_dir/posit_mult_sim | tee sim.log \
	|| { echo "build or simulation run failed"; exit 1; }
grep -q "^TEST PASS$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// ==== include/posit_tb_encode.svh ====
`ifndef POSIT_TB_ENCODE_SVH
`define POSIT_TB_ENCODE_SVH

// one stimulus row with its expected outputs
typedef struct packed {
	logic [posit_cfg_pkg::POSIT_W-1:0] a;
	logic [posit_cfg_pkg::POSIT_W-1:0] b;
	logic [posit_cfg_pkg::POSIT_W-1:0] result;
	logic                              inf;
	logic                              zero;
} mult_row_s;

// posit<32,6> word for 2^e, e = 64k + x
function automatic logic [31:0] pow2_word(input int e);
	int          k;
	int          pos;
	logic [31:0] w;
	k   = e >>> 6;
	w   = '0;
	// bit 30 is the first regime bit, below the sign
	pos = 30;
	if (k >= 0) begin
		// k+1 ones, the zero terminator is already there
		for (int i = 0; i <= k; i++) begin
			w[pos] = 1'b1;
			pos--;
		end
		pos--;
	end else begin
		// -k zeros then a one
		pos = pos + k;
		w[pos] = 1'b1;
		pos--;
	end
	// six exponent bits, fraction stays zero
	for (int i = 5; i >= 0; i--) begin
		w[pos] = e[i];
		pos--;
	end
	return w;
endfunction

function automatic mult_row_s make_row(
	input logic [31:0] a,
	input logic [31:0] b,
	input logic [31:0] result,
	input logic        inf,
	input logic        zero
);
	mult_row_s row;
	row.a      = a;
	row.b      = b;
	row.result = result;
	row.inf    = inf;
	row.zero   = zero;
	return row;
endfunction

// 2^p * 2^q is exactly 2^(p+q)
function automatic mult_row_s pow2_row(input int p, input int q);
	return make_row(pow2_word(p), pow2_word(q), pow2_word(p + q), 1'b0, 1'b0);
endfunction

`endif

// ==== testbench/posit_mult_tb.sv ====
`timescale 1ns/1ps

module posit_mult_tb;

	`include "posit_tb_encode.svh"

	localparam logic [31:0] ONE_WORD     = 32'h4000_0000;
	localparam logic [31:0] NEG_ONE_WORD = 32'hC000_0000;
	localparam logic [31:0] NAR          = posit_cfg_pkg::NAR_WORD;
	// cycles allowed after the last row before giving up on done_o
	localparam int DRAIN_LIMIT = 20;

	logic        clk = 1'b0;
	logic        reset_i;
	logic        valid_i;
	logic [31:0] a_i;
	logic [31:0] b_i;
	logic [31:0] result_o;
	logic        done_o;
	logic        inf_o;
	logic        zero_o;

	int          cycle = 0;
	int          error_count;
	int          tests_run;
	int          tests_failed;
	logic [31:0] rand_state;
	mult_row_s   table_q[$];
	// expected results in issue order, with the cycle each one is due
	mult_row_s   exp_q[$];
	int          due_q[$];

	posit_mult dut_i (
		.clk      (clk),
		.reset_i  (reset_i),
		.valid_i  (valid_i),
		.a_i      (a_i),
		.b_i      (b_i),
		.result_o (result_o),
		.done_o   (done_o),
		.inf_o    (inf_o),
		.zero_o   (zero_o)
	);

	always #50 clk = ~clk;

	// counts rising edges, sampled on the falling edge
	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	//////////////////////////////
	// random sources
	//////////////////////////////

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// exponent in -100 .. 100
	function automatic int rand_exponent();
		logic [31:0] r;
		r = next_rand();
		return int'(r[31:8] % 24'd201) - 100;
	endfunction

	// short regime of either kind, random sign
	function automatic logic [31:0] rand_normal();
		logic [31:0] r;
		logic [31:0] x;
		r = next_rand();
		x = {1'b0, r[30], ~r[30], r[28:0]};
		return r[31] ? -x : x;
	endfunction

	//////////////////////////////
	// checking
	//////////////////////////////

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Mismatch %s: got 0x%08h, expected 0x%08h at cycle %0d",
				name, got, expected, cycle);
			error_count++;
		end
	endtask

	// one result per done_o, oldest expectation first
	task automatic check_outputs();
		if (done_o === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("done_o is high at cycle %0d with no result pending", cycle);
				error_count++;
			end else begin
				check_equal("result_o", result_o, exp_q[0].result);
				check_equal("inf_o", 32'(inf_o), 32'(exp_q[0].inf));
				check_equal("zero_o", 32'(zero_o), 32'(exp_q[0].zero));
				check_equal("done_o cycle", cycle, due_q[0]);
				void'(exp_q.pop_front());
				void'(due_q.pop_front());
			end
		end
	endtask

	task automatic report_test(input string name, input int rows, input int errs);
		tests_run++;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("%s: %0d rows, %0d errors", name, rows, errs);
	endtask

	// drive rows back to back on falling edges, then drain the pipeline
	task automatic run_table(input string name);
		int next_row;
		int wait_cycles;
		int err_start;
		err_start   = error_count;
		next_row    = 0;
		wait_cycles = 0;
		while ((next_row < table_q.size() || exp_q.size() != 0) &&
			wait_cycles < DRAIN_LIMIT) begin
			@(negedge clk);
			check_outputs();
			if (next_row < table_q.size()) begin
				a_i     = table_q[next_row].a;
				b_i     = table_q[next_row].b;
				valid_i = 1'b1;
				exp_q.push_back(table_q[next_row]);
				// valid in this cycle, done LATENCY cycles on
				due_q.push_back(cycle + posit_cfg_pkg::LATENCY);
				next_row++;
			end else begin
				valid_i = 1'b0;
				wait_cycles++;
			end
		end
		valid_i = 1'b0;
		if (exp_q.size() != 0) begin
			$display("%s: done_o never arrived for %0d results", name, exp_q.size());
			error_count++;
			exp_q.delete();
			due_q.delete();
		end
		report_test(name, table_q.size(), error_count - err_start);
		table_q.delete();
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin
		int          err_start;
		logic [31:0] x;
		reset_i      = 1'b1;
		valid_i      = 1'b0;
		a_i          = '0;
		b_i          = '0;
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		rand_state   = 32'he299;
		repeat (2) @(negedge clk);
		reset_i = 1'b0;

		// no done_o before the first valid
		err_start = error_count;
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			check_equal("done_o", 32'(done_o), 32'd0);
		end
		report_test("idle after reset", 4, error_count - err_start);

		// crosses regime boundaries in both directions
		for (int i = 0; i < 16; i++) begin
			table_q.push_back(pow2_row(rand_exponent(), rand_exponent()));
		end
		run_table("powers of two");

		for (int i = 0; i < 8; i++) begin
			x = rand_normal();
			table_q.push_back(make_row(ONE_WORD, x, x, 1'b0, 1'b0));
			table_q.push_back(make_row(NEG_ONE_WORD, x, -x, 1'b0, 1'b0));
		end
		run_table("identity and sign");

		// below half, exact tie, above half
		table_q.push_back(make_row(32'h4000_0001, 32'h4000_0001, 32'h4000_0002, 1'b0, 1'b0));
		table_q.push_back(make_row(32'h4000_0800, 32'h4000_0800, 32'h4000_1000, 1'b0, 1'b0));
		table_q.push_back(make_row(32'h4000_0801, 32'h4000_0801, 32'h4000_1003, 1'b0, 1'b0));
		run_table("rounding");

		// NaR outranks zero, normal rows in between
		x = rand_normal();
		table_q.push_back(make_row(x, 32'h0, 32'h0, 1'b0, 1'b1));
		table_q.push_back(make_row(32'h0, NEG_ONE_WORD, 32'h0, 1'b0, 1'b1));
		table_q.push_back(make_row(32'h0, 32'h0, 32'h0, 1'b0, 1'b1));
		table_q.push_back(pow2_row(70, -3));
		table_q.push_back(make_row(NAR, x, NAR, 1'b1, 1'b0));
		table_q.push_back(make_row(ONE_WORD, NAR, NAR, 1'b1, 1'b0));
		table_q.push_back(make_row(NAR, 32'h0, NAR, 1'b1, 1'b0));
		table_q.push_back(make_row(32'h0, NAR, NAR, 1'b1, 1'b0));
		table_q.push_back(make_row(NAR, NAR, NAR, 1'b1, 1'b0));
		table_q.push_back(make_row(ONE_WORD, x, x, 1'b0, 1'b0));
		run_table("specials");

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== rtl/posit_mult.sv ====
`timescale 1ns/1ps

module posit_mult (
	input  logic                              clk,
	input  logic                              reset_i,
	input  logic                              valid_i,
	input  logic [posit_cfg_pkg::POSIT_W-1:0] a_i,
	input  logic [posit_cfg_pkg::POSIT_W-1:0] b_i,
	output logic [posit_cfg_pkg::POSIT_W-1:0] result_o,
	output logic                              done_o,
	output logic                              inf_o,
	output logic                              zero_o
);

	// decoded operands, same cycle as the inputs
	posit_types_pkg::decoded_operand_s a_dec;
	posit_types_pkg::decoded_operand_s b_dec;

	// execute to result, three stages in
	posit_types_pkg::product_s         product;
	logic                              product_valid;

	//////////////////////////////
	// operand decode
	//////////////////////////////

	posit_decode dec_a (
		.operand_i (a_i),
		.decoded_o (a_dec)
	);

	posit_decode dec_b (
		.operand_i (b_i),
		.decoded_o (b_dec)
	);

	//////////////////////////////
	// stages 1 to 3
	//////////////////////////////

	posit_execute exec_i (
		.clk       (clk),
		.reset_i   (reset_i),
		.valid_i   (valid_i),
		.a_i       (a_dec),
		.b_i       (b_dec),
		.product_o (product),
		.valid_o   (product_valid)
	);

	//////////////////////////////
	// stages 4 and 5
	//////////////////////////////

	posit_result result_i (
		.clk       (clk),
		.reset_i   (reset_i),
		.valid_i   (product_valid),
		.product_i (product),
		.result_o  (result_o),
		.done_o    (done_o),
		.inf_o     (inf_o),
		.zero_o    (zero_o)
	);

endmodule

// ==== rtl/posit_result.sv ====
`timescale 1ns/1ps

module posit_result (
	input  logic                              clk,
	input  logic                              reset_i,
	input  logic                              valid_i,
	input  posit_types_pkg::product_s         product_i,
	output logic [posit_cfg_pkg::POSIT_W-1:0] result_o,
	output logic                              done_o,
	output logic                              inf_o,
	output logic                              zero_o
);

	// stage 4 combinational, regime split
	logic signed [posit_cfg_pkg::REGIME_W-1:0] k;
	// regime fill value, 1 for k >= 0
	logic                                      fill;
	logic [posit_cfg_pkg::REGIME_W-1:0]        shift_full;
	logic                                      sat;
	logic [posit_cfg_pkg::RUN_W-1:0]           shift_amt;

	// stage 4 combinational, packing and rounding
	logic [posit_cfg_pkg::PACK_W-1:0]  packed_w;
	logic [posit_cfg_pkg::PACK_W-1:0]  shifted_w;
	logic [posit_cfg_pkg::POSIT_W-2:0] body;
	logic                              lsb;
	logic                              guard;
	logic                              round_bit;
	logic                              sticky;
	logic                              ulp;
	logic [posit_cfg_pkg::POSIT_W-1:0] mag_rnd;

	// stage 4 registers
	logic [posit_cfg_pkg::POSIT_W-1:0] mag_q;
	logic                              sign_q;
	posit_types_pkg::result_flags_s    flags_q;
	logic                              valid_q;

	// stage 5 combinational
	logic [posit_cfg_pkg::POSIT_W-1:0] signed_w;
	logic [posit_cfg_pkg::POSIT_W-1:0] out_w;

	//////////////////////////////
	// regime packing
	//////////////////////////////

	// upper scale bits are floor(scale / 2^EXP_W), the low bits are the exponent
	assign k    = product_i.scale[posit_cfg_pkg::SCALE_W-1 -: posit_cfg_pkg::REGIME_W];
	assign fill = ~k[posit_cfg_pkg::REGIME_W-1];

	// extra fill bits beyond the first, k for k >= 0 and -k-1 below
	assign shift_full = k ^ {posit_cfg_pkg::REGIME_W{k[posit_cfg_pkg::REGIME_W-1]}};
	// past this point the regime covers the whole body
	assign sat        = (shift_full >= posit_cfg_pkg::REGIME_W'(posit_cfg_pkg::SAT_SHIFT));
	assign shift_amt  = sat ? posit_cfg_pkg::RUN_W'(posit_cfg_pkg::SAT_SHIFT)
	                        : shift_full[posit_cfg_pkg::RUN_W-1:0];

	// fill bits, terminator, exponent, fraction below the hidden bit
	assign packed_w = {{posit_cfg_pkg::POSIT_W{fill}}, ~fill,
	                   product_i.scale[posit_cfg_pkg::EXP_W-1:0],
	                   product_i.mant[posit_cfg_pkg::PROD_W-2:0]};
	// the right shift pulls more fill bits into the body window
	assign shifted_w = packed_w >> shift_amt;

	// body window sits just above the guard bit
	assign body = shifted_w[posit_cfg_pkg::GUARD_POS + posit_cfg_pkg::POSIT_W - 1 -:
	                        posit_cfg_pkg::POSIT_W - 1];

	//////////////////////////////
	// round to nearest even
	//////////////////////////////

	assign lsb       = shifted_w[posit_cfg_pkg::GUARD_POS + 1];
	assign guard     = shifted_w[posit_cfg_pkg::GUARD_POS];
	assign round_bit = shifted_w[posit_cfg_pkg::GUARD_POS - 1];
	assign sticky    = |shifted_w[posit_cfg_pkg::GUARD_POS-2:0];
	// above half rounds up, an exact tie rounds to the even neighbour
	assign ulp       = guard & (round_bit | sticky | lsb);

	// a full regime clamps to maxpos or minpos, with no rounding
	assign mag_rnd = sat ? {1'b0, body | {{(posit_cfg_pkg::POSIT_W-2){1'b0}}, ~fill}}
	                     : {1'b0, body} + posit_cfg_pkg::POSIT_W'(ulp);

	always_ff @(posedge clk) begin
		mag_q   <= mag_rnd;
		sign_q  <= product_i.sign;
		flags_q <= product_i.flags;
	end

	//////////////////////////////
	// sign restore and specials
	//////////////////////////////

	assign signed_w = sign_q ? -mag_q : mag_q;

	always_comb begin
		if (flags_q.inf) begin
			out_w = posit_cfg_pkg::NAR_WORD;
		end else if (flags_q.zero) begin
			out_w = '0;
		end else begin
			out_w = signed_w;
		end
	end

	always_ff @(posedge clk) begin
		result_o <= out_w;
		inf_o    <= flags_q.inf;
		zero_o   <= flags_q.zero;
	end

	// only the strobes are cleared
	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid_q <= 1'b0;
			done_o  <= 1'b0;
		end else begin
			valid_q <= valid_i;
			done_o  <= valid_q;
		end
	end

endmodule

// ==== rtl/posit_execute.sv ====
`timescale 1ns/1ps

module posit_execute (
	input  logic                              clk,
	input  logic                              reset_i,
	input  logic                              valid_i,
	input  posit_types_pkg::decoded_operand_s a_i,
	input  posit_types_pkg::decoded_operand_s b_i,
	output posit_types_pkg::product_s         product_o,
	output logic                              valid_o
);

	// stage 1, operand registers
	posit_types_pkg::decoded_operand_s a_q1;
	posit_types_pkg::decoded_operand_s b_q1;
	logic                              valid_q1;

	// stage 2, raw product and the operand fields still needed
	posit_types_pkg::decoded_operand_s a_q2;
	posit_types_pkg::decoded_operand_s b_q2;
	logic [posit_cfg_pkg::PROD_W-1:0]  prod_q2;
	logic                              valid_q2;

	// stage 3 combinational
	logic                                     ovf;
	logic [posit_cfg_pkg::PROD_W-1:0]         prod_norm;
	logic signed [posit_cfg_pkg::SCALE_W-1:0] scale_sum;
	posit_types_pkg::result_flags_s           flags;
	logic                                     any_nar;
	logic                                     any_zero;

	//////////////////////////////
	// valid pipe
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid_q1 <= 1'b0;
			valid_q2 <= 1'b0;
			valid_o  <= 1'b0;
		end else begin
			valid_q1 <= valid_i;
			valid_q2 <= valid_q1;
			valid_o  <= valid_q2;
		end
	end

	//////////////////////////////
	// datapath
	//////////////////////////////

	// top bit set means the product is already in [2,4)
	assign ovf = prod_q2[posit_cfg_pkg::PROD_W-1];
	// product in [1,2) moves up one place so the leading one sits on top
	assign prod_norm = ovf ? prod_q2 : {prod_q2[posit_cfg_pkg::PROD_W-2:0], 1'b0};

	// carry out of the mantissa multiply bumps the scale by one
	assign scale_sum = a_q2.scale + b_q2.scale
	                 + {{(posit_cfg_pkg::SCALE_W-1){1'b0}}, ovf};

	// NaR wins over zero, so NaR * 0 is NaR
	assign any_nar  = (a_q2.op_class == posit_types_pkg::CLASS_NAR) ||
	                  (b_q2.op_class == posit_types_pkg::CLASS_NAR);
	assign any_zero = (a_q2.op_class == posit_types_pkg::CLASS_ZERO) ||
	                  (b_q2.op_class == posit_types_pkg::CLASS_ZERO);
	assign flags.inf  = any_nar;
	assign flags.zero = any_zero & ~any_nar;

	always_ff @(posedge clk) begin
		// stage 1
		a_q1 <= a_i;
		b_q1 <= b_i;
		// stage 2, first half of the multiply
		a_q2    <= a_q1;
		b_q2    <= b_q1;
		prod_q2 <= posit_cfg_pkg::PROD_W'(a_q1.mant) * posit_cfg_pkg::PROD_W'(b_q1.mant);
		// stage 3, normalised product with sign, scale and flags
		product_o.sign       <= a_q2.sign ^ b_q2.sign;
		product_o.scale      <= scale_sum;
		product_o.mant       <= prod_norm;
		product_o.norm_shift <= ovf;
		product_o.flags      <= flags;
	end

endmodule

// ==== rtl/posit_decode.sv ====
`timescale 1ns/1ps

module posit_decode (
	input  logic [posit_cfg_pkg::POSIT_W-1:0] operand_i,
	output posit_types_pkg::decoded_operand_s decoded_o
);

	logic                                      sign;
	logic                                      is_zero;
	logic                                      is_nar;
	logic [posit_cfg_pkg::POSIT_W-1:0]         mag;
	// value of the first regime bit
	logic                                      rc;
	logic [posit_cfg_pkg::RUN_W-1:0]           run;
	logic signed [posit_cfg_pkg::REGIME_W-1:0] regime;
	logic [posit_cfg_pkg::POSIT_W-1:0]         body;
	logic [posit_cfg_pkg::EXP_W-1:0]           exp_bits;

	//////////////////////////////
	// sign and special words
	//////////////////////////////

	assign sign    = operand_i[posit_cfg_pkg::POSIT_W-1];
	assign is_zero = (operand_i == '0);
	assign is_nar  = (operand_i == posit_cfg_pkg::NAR_WORD);

	// negative posits are decoded from their two's complement
	assign mag = sign ? -operand_i : operand_i;
	assign rc  = mag[posit_cfg_pkg::POSIT_W-2];

	//////////////////////////////
	// regime run length
	//////////////////////////////

	// priority search from the lsb up, the highest mismatch wins
	// a word with no terminator keeps the full run of 31
	always_comb begin
		run = '1;
		for (int i = 0; i <= posit_cfg_pkg::POSIT_W - 2; i++) begin
			if (mag[i] != rc) begin
				run = posit_cfg_pkg::RUN_W'(posit_cfg_pkg::POSIT_W - 2 - i);
			end
		end
	end

	// run of ones gives run-1, run of zeros gives -run
	assign regime = rc ? posit_cfg_pkg::REGIME_W'(run) - posit_cfg_pkg::REGIME_W'(1)
	                   : posit_cfg_pkg::REGIME_W'(0) - posit_cfg_pkg::REGIME_W'(run);

	//////////////////////////////
	// exponent and fraction
	//////////////////////////////

	// drop sign and first regime bit, then shift out the rest of the run
	// and the terminator so the exponent lands on top
	assign body     = {mag[posit_cfg_pkg::POSIT_W-3:0], 2'b00} << run;
	assign exp_bits = body[posit_cfg_pkg::POSIT_W-1 -: posit_cfg_pkg::EXP_W];

	always_comb begin
		decoded_o.sign = sign;
		if (is_nar) begin
			decoded_o.op_class = posit_types_pkg::CLASS_NAR;
		end else if (is_zero) begin
			decoded_o.op_class = posit_types_pkg::CLASS_ZERO;
		end else begin
			decoded_o.op_class = posit_types_pkg::CLASS_NORMAL;
		end
		// regime in the upper bits, exponent in the lower bits
		decoded_o.scale = {regime, exp_bits};
		// hidden bit is clear only for a zero word
		decoded_o.mant  = {~is_zero, body[posit_cfg_pkg::FRAC_W-1:0]};
	end

endmodule

// ==== rtl/posit_types_pkg.sv ====
package posit_types_pkg;

	//////////////////////////////
	// operand classification
	//////////////////////////////

	// zero and NaR bypass the datapath through flags
	typedef enum logic [1:0] {
		CLASS_ZERO   = 2'd0,
		CLASS_NORMAL = 2'd1,
		CLASS_NAR    = 2'd2
	} operand_class_e;

	//////////////////////////////
	// stage payloads
	//////////////////////////////

	// one unpacked operand, decoder to execute
	typedef struct packed {
		// sign of the original word
		logic                                     sign;
		operand_class_e                           op_class;
		// {regime, exponent} as one two's-complement number
		logic signed [posit_cfg_pkg::SCALE_W-1:0] scale;
		// hidden bit then fraction, left aligned
		logic [posit_cfg_pkg::MANT_W-1:0]         mant;
	} decoded_operand_s;

	// special-case outcome, travels with the product
	typedef struct packed {
		// either operand is NaR
		logic inf;
		// an operand is zero and none is NaR
		logic zero;
	} result_flags_s;

	// execute to result
	typedef struct packed {
		// xor of the operand signs
		logic                                     sign;
		// sum of both scales plus the normalise carry
		logic signed [posit_cfg_pkg::SCALE_W-1:0] scale;
		// product with its leading one in the top bit
		logic [posit_cfg_pkg::PROD_W-1:0]         mant;
		// raw product had its top bit set, no shift was needed
		logic                                     norm_shift;
		result_flags_s                            flags;
	} product_s;

endpackage

// ==== rtl/posit_cfg_pkg.sv ====
package posit_cfg_pkg;

	//////////////////////////////
	// posit<32,6> word format
	//////////////////////////////

	// full posit word, sign bit included
	localparam int POSIT_W = 32;
	// exponent field after the regime terminator
	localparam int EXP_W = 6;
	// regime run count, longest run is 31 bits
	localparam int RUN_W = 5;
	// fraction bits kept by the decoder, widest case with a 2-bit regime
	localparam int FRAC_W = POSIT_W - EXP_W;
	// mantissa with the hidden bit on top
	localparam int MANT_W = FRAC_W + 1;
	// full product of two mantissas
	localparam int PROD_W = 2 * MANT_W;

	//////////////////////////////
	// scale arithmetic
	//////////////////////////////

	// signed regime value, range -31 .. 30 per operand, -62 .. 61 after the sum
	localparam int REGIME_W = 7;
	// scale = regime * 2^EXP_W + exponent, wide enough for the sum of two operands
	localparam int SCALE_W = REGIME_W + EXP_W;

	// packing word in the result stage
	// POSIT_W fill bits, terminator, exponent and the product below the hidden bit
	localparam int PACK_W = POSIT_W + EXP_W + PROD_W;
	// guard bit position once the word has been shifted
	localparam int GUARD_POS = PACK_W - 2 * POSIT_W + 1;
	// shift where the regime has taken the whole body
	localparam int SAT_SHIFT = POSIT_W - 2;

	// not-a-real, sign bit only
	localparam logic [POSIT_W-1:0] NAR_WORD = {1'b1, {(POSIT_W-1){1'b0}}};

	// register stages from valid_i to done_o
	localparam int LATENCY = 5;

endpackage
